//--- procci_pkg.sv
package procci_pkg;

  // Word and address sizes
  localparam int word_w    = 32;
  localparam int addr_w    = 8;
  localparam int mem_depth = 256;

  // Core register file
  localparam int reg_count = 4;
  localparam int reg_idx_w = $clog2(reg_count);

  // Core reset hold after a run strobe, in clock cycles
  localparam int boot_cycles = 8;
  localparam int boot_cnt_w  = $clog2(boot_cycles);

  typedef logic [word_w-1:0]     word_t;
  typedef logic [addr_w-1:0]     addr_t;
  typedef logic [boot_cnt_w-1:0] boot_cnt_t;

  // Opcode in the top nibble of every instruction
  // Anything not listed is executed as a halt
  typedef enum logic [3:0] {
    op_li   = 4'h1,
    op_add  = 4'h2,
    op_dec  = 4'h3,
    op_lw   = 4'h4,
    op_sw   = 4'h5,
    op_bnz  = 4'h6,
    op_halt = 4'h7
  } opcode_t;

  // Instruction field positions
  localparam int op_msb  = 31;
  localparam int op_lsb  = 28;
  localparam int rd_msb  = 27;
  localparam int rd_lsb  = 26;
  localparam int rs_msb  = 25;
  localparam int rs_lsb  = 24;
  // Immediate, low addr_w bits double as the word address
  localparam int imm_msb = 15;
  localparam int imm_lsb = 0;

endpackage

//--- reset_boot.sv
`timescale 1ns/1ps

module reset_boot (
  input  logic clk,
  input  logic rst_i,
  input  logic run_i,
  output logic core_rst_o
);

  typedef enum logic [1:0] {
    st_hold,
    st_boot,
    st_run
  } boot_state_t;

  boot_state_t           state;
  procci_pkg::boot_cnt_t cnt;

  // Hold until the host strobes run, then count down the boot period
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state <= st_hold;
      cnt   <= '0;
    end else if (run_i) begin
      // Any run strobe restarts the hold, also while running
      state <= st_boot;
      cnt   <= procci_pkg::boot_cnt_t'(procci_pkg::boot_cycles - 1);
    end else if (state == st_boot) begin
      if (cnt == '0) begin
        state <= st_run;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // Core stays in reset in every state but run
  assign core_rst_o = (state != st_run);

endmodule

//--- bus_memory.sv
`timescale 1ns/1ps

module bus_memory (
  input  logic              clk,
  input  logic              rst_i,

  // Instruction port
  input  logic              ifetch_stb_i,
  input  procci_pkg::addr_t ifetch_addr_i,
  output logic              ifetch_ack_o,
  output procci_pkg::word_t ifetch_data_o,

  // Core data port
  input  logic              dmem_stb_i,
  input  logic              dmem_we_i,
  input  procci_pkg::addr_t dmem_addr_i,
  input  procci_pkg::word_t dmem_wdata_i,
  output logic              dmem_ack_o,
  output procci_pkg::word_t dmem_rdata_o,

  // Host load and readback port
  input  logic              host_we_i,
  input  logic              host_re_i,
  input  procci_pkg::addr_t host_addr_i,
  input  procci_pkg::word_t host_wdata_i,
  output procci_pkg::word_t host_rdata_o,
  output logic              host_rvalid_o
);

  procci_pkg::word_t mem [procci_pkg::mem_depth];

  // Shared data port
  logic              host_sel;
  logic              port_we;
  logic              port_re;
  procci_pkg::addr_t port_addr;
  procci_pkg::word_t port_wdata;
  procci_pkg::word_t port_rdata;

  // Host takes the data port whenever it drives a request
  assign host_sel   = host_we_i | host_re_i;
  assign port_addr  = host_sel ? host_addr_i : dmem_addr_i;
  assign port_wdata = host_sel ? host_wdata_i : dmem_wdata_i;
  assign port_we    = host_sel ? host_we_i : (dmem_stb_i & dmem_we_i);
  assign port_re    = host_sel ? host_re_i : (dmem_stb_i & ~dmem_we_i);

  // Array with one write port and two registered read ports
  always_ff @(posedge clk) begin
    if (port_we) begin
      mem[port_addr] <= port_wdata;
    end
    if (port_re) begin
      port_rdata <= mem[port_addr];
    end
    if (ifetch_stb_i) begin
      ifetch_data_o <= mem[ifetch_addr_i];
    end
  end

  // Acks follow their strobe by exactly one cycle
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ifetch_ack_o  <= 1'b0;
      dmem_ack_o    <= 1'b0;
      host_rvalid_o <= 1'b0;
    end else begin
      ifetch_ack_o  <= ifetch_stb_i;
      dmem_ack_o    <= dmem_stb_i;
      host_rvalid_o <= host_re_i;
    end
  end

  // Core and host see the same read register
  assign dmem_rdata_o = port_rdata;
  assign host_rdata_o = port_rdata;

endmodule

//--- mini_core.sv
`timescale 1ns/1ps

module mini_core (
  input  logic              clk,
  input  logic              rst_i,

  // Instruction bus
  output logic              ifetch_stb_o,
  output procci_pkg::addr_t ifetch_addr_o,
  input  logic              ifetch_ack_i,
  input  procci_pkg::word_t ifetch_data_i,

  // Data bus
  output logic              dmem_stb_o,
  output logic              dmem_we_o,
  output procci_pkg::addr_t dmem_addr_o,
  output procci_pkg::word_t dmem_wdata_o,
  input  logic              dmem_ack_i,
  input  procci_pkg::word_t dmem_rdata_i,

  output logic              halted_o
);

  // Idle gives one quiet cycle out of reset before the first fetch
  typedef enum logic [2:0] {
    st_idle,
    st_fetch,
    st_fetch_wait,
    st_exec,
    st_mem_wait,
    st_halted
  } core_state_t;

  core_state_t       state;
  procci_pkg::addr_t pc;
  procci_pkg::word_t ir;
  procci_pkg::word_t regs [procci_pkg::reg_count];

  // Decoded instruction fields
  procci_pkg::opcode_t              opcode;
  logic [procci_pkg::reg_idx_w-1:0] rd;
  logic [procci_pkg::reg_idx_w-1:0] rs;
  procci_pkg::word_t                imm;
  procci_pkg::addr_t                target;
  procci_pkg::word_t                rd_val;
  procci_pkg::word_t                rs_val;

  assign opcode = procci_pkg::opcode_t'(ir[procci_pkg::op_msb:procci_pkg::op_lsb]);
  assign rd     = ir[procci_pkg::rd_msb:procci_pkg::rd_lsb];
  assign rs     = ir[procci_pkg::rs_msb:procci_pkg::rs_lsb];
  assign imm    = procci_pkg::word_t'(ir[procci_pkg::imm_msb:procci_pkg::imm_lsb]);
  assign target = ir[procci_pkg::imm_lsb +: procci_pkg::addr_w];
  assign rd_val = regs[rd];
  assign rs_val = regs[rs];

  // Fetch strobe lasts the single fetch state
  assign ifetch_stb_o  = (state == st_fetch);
  assign ifetch_addr_o = pc;
  assign halted_o      = (state == st_halted);

  // Control, program counter and register file
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state      <= st_idle;
      pc         <= '0;
      dmem_stb_o <= 1'b0;
      for (int i = 0; i < procci_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else begin
      // Data strobe is a one-cycle pulse
      dmem_stb_o <= 1'b0;
      case (state)
        st_idle: begin
          state <= st_fetch;
        end
        st_fetch: begin
          state <= st_fetch_wait;
        end
        st_fetch_wait: begin
          if (ifetch_ack_i) begin
            state <= st_exec;
          end
        end
        st_exec: begin
          state <= st_fetch;
          pc    <= pc + 1'b1;
          case (opcode)
            procci_pkg::op_li: begin
              regs[rd] <= imm;
            end
            procci_pkg::op_add: begin
              regs[rd] <= rd_val + rs_val;
            end
            procci_pkg::op_dec: begin
              regs[rd] <= rd_val - 1'b1;
            end
            procci_pkg::op_lw, procci_pkg::op_sw: begin
              dmem_stb_o <= 1'b1;
              state      <= st_mem_wait;
            end
            procci_pkg::op_bnz: begin
              if (rs_val != '0) begin
                pc <= target;
              end
            end
            default: begin
              // Halt and every unknown opcode stop here
              state <= st_halted;
            end
          endcase
        end
        st_mem_wait: begin
          if (dmem_ack_i) begin
            if (opcode == procci_pkg::op_lw) begin
              regs[rd] <= dmem_rdata_i;
            end
            state <= st_fetch;
          end
        end
        st_halted: begin
          state <= st_halted;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Instruction and data bus payload
  always_ff @(posedge clk) begin
    if ((state == st_fetch_wait) && ifetch_ack_i) begin
      ir <= ifetch_data_i;
    end
    if (state == st_exec) begin
      dmem_we_o    <= (opcode == procci_pkg::op_sw);
      dmem_addr_o  <= target;
      dmem_wdata_o <= rd_val;
    end
  end

endmodule

//--- procci_top.sv
`timescale 1ns/1ps

module procci_top (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              run_i,

  // Host port
  input  logic              host_we_i,
  input  logic              host_re_i,
  input  procci_pkg::addr_t host_addr_i,
  input  procci_pkg::word_t host_wdata_i,
  output procci_pkg::word_t host_rdata_o,
  output logic              host_rvalid_o,

  output logic              halted_o
);

  logic core_rst;

  // Instruction bus
  logic              ifetch_stb;
  procci_pkg::addr_t ifetch_addr;
  logic              ifetch_ack;
  procci_pkg::word_t ifetch_data;

  // Data bus
  logic              dmem_stb;
  logic              dmem_we;
  procci_pkg::addr_t dmem_addr;
  procci_pkg::word_t dmem_wdata;
  logic              dmem_ack;
  procci_pkg::word_t dmem_rdata;

  reset_boot i_boot (
    .clk        (clk),
    .rst_i      (rst_i),
    .run_i      (run_i),
    .core_rst_o (core_rst)
  );

  bus_memory i_mem (
    .clk           (clk),
    .rst_i         (rst_i),
    .ifetch_stb_i  (ifetch_stb),
    .ifetch_addr_i (ifetch_addr),
    .ifetch_ack_o  (ifetch_ack),
    .ifetch_data_o (ifetch_data),
    .dmem_stb_i    (dmem_stb),
    .dmem_we_i     (dmem_we),
    .dmem_addr_i   (dmem_addr),
    .dmem_wdata_i  (dmem_wdata),
    .dmem_ack_o    (dmem_ack),
    .dmem_rdata_o  (dmem_rdata),
    .host_we_i     (host_we_i),
    .host_re_i     (host_re_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_rdata_o  (host_rdata_o),
    .host_rvalid_o (host_rvalid_o)
  );

  // Core runs from the boot sequencer reset, not the board reset
  mini_core i_core (
    .clk           (clk),
    .rst_i         (core_rst),
    .ifetch_stb_o  (ifetch_stb),
    .ifetch_addr_o (ifetch_addr),
    .ifetch_ack_i  (ifetch_ack),
    .ifetch_data_i (ifetch_data),
    .dmem_stb_o    (dmem_stb),
    .dmem_we_o     (dmem_we),
    .dmem_addr_o   (dmem_addr),
    .dmem_wdata_o  (dmem_wdata),
    .dmem_ack_i    (dmem_ack),
    .dmem_rdata_i  (dmem_rdata),
    .halted_o      (halted_o)
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
  end

  always #2 clk_o = ~clk_o;

endmodule

//--- procci_chk.sv
`timescale 1ns/1ps

module procci_chk (
  input logic clk,
  input logic rst_i,
  input logic ifetch_stb_i,
  input logic ifetch_ack_o,
  input logic dmem_stb_i,
  input logic dmem_ack_o,
  input logic host_we_i,
  input logic host_re_i,
  input logic host_rvalid_o
);

  // Every strobe gets its ack on the next cycle and only then
  a_ifetch_ack : assert property (@(posedge clk) disable iff (rst_i)
    ifetch_ack_o == $past(ifetch_stb_i))
    else $error("instruction ack does not follow its strobe by one cycle");

  a_dmem_ack : assert property (@(posedge clk) disable iff (rst_i)
    dmem_ack_o == $past(dmem_stb_i))
    else $error("data ack does not follow its strobe by one cycle");

  a_host_valid : assert property (@(posedge clk) disable iff (rst_i)
    host_rvalid_o == $past(host_re_i))
    else $error("host read valid does not follow the read by one cycle");

  // No new strobe while an ack is still due
  a_ifetch_single : assert property (@(posedge clk) disable iff (rst_i)
    ifetch_stb_i |=> !ifetch_stb_i)
    else $error("second instruction strobe before the ack");

  a_dmem_single : assert property (@(posedge clk) disable iff (rst_i)
    dmem_stb_i |=> !dmem_stb_i)
    else $error("second data strobe before the ack");

  // Host stays off the memory while the core uses its buses
  a_host_idle_core : assert property (@(posedge clk) disable iff (rst_i)
    (host_we_i || host_re_i) |-> !(ifetch_stb_i || dmem_stb_i || ifetch_ack_o || dmem_ack_o))
    else $error("host access while the core is running");

endmodule

bind bus_memory procci_chk i_chk (
  .clk           (clk),
  .rst_i         (rst_i),
  .ifetch_stb_i  (ifetch_stb_i),
  .ifetch_ack_o  (ifetch_ack_o),
  .dmem_stb_i    (dmem_stb_i),
  .dmem_ack_o    (dmem_ack_o),
  .host_we_i     (host_we_i),
  .host_re_i     (host_re_i),
  .host_rvalid_o (host_rvalid_o)
);

//--- procci_tb.sv
`timescale 1ns/1ps

module procci_tb;

  logic              clk;
  logic              rst_i;
  logic              run_i;
  logic              host_we_i;
  logic              host_re_i;
  procci_pkg::addr_t host_addr_i;
  procci_pkg::word_t host_wdata_i;
  procci_pkg::word_t host_rdata_o;
  logic              host_rvalid_o;
  logic              halted_o;

  // Host view of memory and the reference image
  procci_pkg::word_t img     [procci_pkg::mem_depth];
  procci_pkg::word_t ref_mem [procci_pkg::mem_depth];
  procci_pkg::word_t exp_q[$];
  string             name_q[$];
  procci_pkg::word_t prog[$];

  int errors;
  int tests;
  int failed_tests;
  int cycles;
  int cycle_limit;

  tb_clock_gen i_clk (.clk_o(clk));

  procci_top i_dut (
    .clk           (clk),
    .rst_i         (rst_i),
    .run_i         (run_i),
    .host_we_i     (host_we_i),
    .host_re_i     (host_re_i),
    .host_addr_i   (host_addr_i),
    .host_wdata_i  (host_wdata_i),
    .host_rdata_o  (host_rdata_o),
    .host_rvalid_o (host_rvalid_o),
    .halted_o      (halted_o)
  );

  function automatic procci_pkg::word_t enc(procci_pkg::opcode_t op, int rd, int rs, int imm);
    return {op, 2'(rd), 2'(rs), 8'h00, 16'(imm)};
  endfunction

  // Depends on every address bit
  function automatic procci_pkg::word_t fill_word(int a);
    return {8'(a), ~8'(a), 8'(a) ^ 8'h5A, 8'(a) + 8'h11};
  endfunction

  // Instruction-set model, runs on ref_mem and returns the instruction count
  // min_cycles counts 3 per instruction plus 2 per load or store
  function automatic int run_reference(output int min_cycles);
    procci_pkg::word_t   regs [4];
    procci_pkg::word_t   ins;
    procci_pkg::addr_t   pc;
    procci_pkg::opcode_t op;
    logic [1:0]          rd;
    logic [1:0]          rs;
    int                  steps;
    bit                  done;
    for (int i = 0; i < 4; i++) regs[i] = '0;
    pc         = '0;
    steps      = 0;
    min_cycles = 0;
    done       = 1'b0;
    while (!done && steps < 5000) begin
      ins   = ref_mem[pc];
      op    = procci_pkg::opcode_t'(ins[31:28]);
      rd    = ins[27:26];
      rs    = ins[25:24];
      steps = steps + 1;
      pc    = pc + 8'd1;
      min_cycles = min_cycles + 3;
      if (op == procci_pkg::op_lw || op == procci_pkg::op_sw) begin
        min_cycles = min_cycles + 2;
      end
      case (op)
        procci_pkg::op_li:  regs[rd] = {16'h0000, ins[15:0]};
        procci_pkg::op_add: regs[rd] = regs[rd] + regs[rs];
        procci_pkg::op_dec: regs[rd] = regs[rd] - 32'd1;
        procci_pkg::op_lw:  regs[rd] = ref_mem[ins[7:0]];
        procci_pkg::op_sw:  ref_mem[ins[7:0]] = regs[rd];
        procci_pkg::op_bnz: begin
          if (regs[rs] != '0) pc = ins[7:0];
        end
        default: done = 1'b1;
      endcase
    end
    return steps;
  endfunction

  task automatic check_word(input string nm, input procci_pkg::word_t exp,
                            input procci_pkg::word_t act);
    if (exp !== act) begin
      $display("FAIL %s: expected %h, actual %h", nm, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string nm, input logic exp, input logic act);
    if (exp !== act) begin
      $display("FAIL %s: expected %b, actual %b", nm, exp, act);
      errors++;
    end
  endtask

  task automatic host_write(input procci_pkg::addr_t a, input procci_pkg::word_t d);
    @(negedge clk);
    host_we_i    = 1'b1;
    host_addr_i  = a;
    host_wdata_i = d;
    img[a]       = d;
    cycle_limit  = cycle_limit + 1;
  endtask

  task automatic host_release();
    @(negedge clk);
    host_we_i = 1'b0;
    host_re_i = 1'b0;
  endtask

  // Data itself is checked by the compare process
  task automatic host_read(input procci_pkg::addr_t a, input procci_pkg::word_t exp,
                           input string nm);
    @(negedge clk);
    host_re_i   = 1'b1;
    host_addr_i = a;
    exp_q.push_back(exp);
    name_q.push_back(nm);
    cycle_limit = cycle_limit + 2;
    @(negedge clk);
    host_re_i = 1'b0;
    check_bit({nm, " rvalid"}, 1'b1, host_rvalid_o);
  endtask

  always @(negedge clk) begin
    if (host_rvalid_o) begin
      if (exp_q.size() == 0) begin
        $display("Read data came back with no read outstanding");
        errors++;
      end else begin
        check_word(name_q.pop_front(), exp_q.pop_front(), host_rdata_o);
      end
    end
  end

  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) host_write(procci_pkg::addr_t'(i), prog[i]);
    host_release();
  endtask

  task automatic finish_test(input string nm, input int err_before);
    @(negedge clk);
    tests++;
    if (errors == err_before) begin
      $display("test %s: pass", nm);
    end else begin
      $display("test %s: fail", nm);
      failed_tests++;
    end
  endtask

  // Run the loaded program and read back the whole memory
  task automatic run_program(input string nm, input bit hold, input procci_pkg::addr_t hold_addr);
    int steps;
    int err_before;
    int min_cycles;
    int start_cycle;
    err_before = errors;
    for (int i = 0; i < procci_pkg::mem_depth; i++) ref_mem[i] = img[i];
    steps = run_reference(min_cycles);
    cycle_limit = cycle_limit + steps * 6 + procci_pkg::boot_cycles + 20;
    @(negedge clk);
    run_i       = 1'b1;
    start_cycle = cycles;
    @(negedge clk);
    run_i = 1'b0;
    if (hold) begin
      for (int i = 0; i < 3; i++) begin
        host_read(hold_addr, img[hold_addr], {nm, " during boot"});
        check_bit({nm, " halted during boot"}, 1'b0, halted_o);
      end
    end else begin
      repeat (procci_pkg::boot_cycles) @(negedge clk);
    end
    while (!halted_o) @(negedge clk);
    // An early halt means the boot hold was cut short
    if (cycles - start_cycle < procci_pkg::boot_cycles + min_cycles) begin
      $display("%s: core halted after %0d cycles, before boot hold and program could finish",
               nm, cycles - start_cycle);
      errors++;
    end
    for (int i = 0; i < procci_pkg::mem_depth; i++) begin
      host_read(procci_pkg::addr_t'(i), ref_mem[i], $sformatf("%s word %0d", nm, i));
    end
    @(negedge clk);
    for (int i = 0; i < procci_pkg::mem_depth; i++) img[i] = ref_mem[i];
    finish_test(nm, err_before);
  endtask

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the core did not halt in time", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  initial begin
    int                err_before;
    int                n;
    procci_pkg::word_t saved;
    void'($urandom(37383));
    errors       = 0;
    tests        = 0;
    failed_tests = 0;
    cycles       = 0;
    cycle_limit  = 3 + 100;
    rst_i        = 1'b1;
    run_i        = 1'b0;
    host_we_i    = 1'b0;
    host_re_i    = 1'b0;
    host_addr_i  = '0;
    host_wdata_i = '0;
    repeat (3) @(negedge clk);
    rst_i = 1'b0;

    for (int i = 0; i < procci_pkg::mem_depth; i++) begin
      host_write(procci_pkg::addr_t'(i), fill_word(i));
    end
    host_release();

    // Host load and readback
    err_before = errors;
    for (int i = 0; i < 16; i++) host_write(procci_pkg::addr_t'(8'h80 + i), $urandom);
    host_release();
    for (int i = 0; i < 16; i++) begin
      host_read(procci_pkg::addr_t'(8'h80 + i), img[8'h80 + i], $sformatf("readback %0d", i));
    end
    finish_test("host_readback", err_before);

    // Result word must stay old through the boot hold
    prog = {};
    prog.push_back(enc(procci_pkg::op_li, 0, 0, 16'h1234));
    prog.push_back(enc(procci_pkg::op_sw, 0, 0, 8'h40));
    prog.push_back(enc(procci_pkg::op_halt, 0, 0, 0));
    load_program();
    run_program("boot_hold", 1'b1, 8'h40);

    // Doubling 0xffff seventeen times wraps past 2^32
    prog = {};
    prog.push_back(enc(procci_pkg::op_li, 0, 0, 16'hFFFF));
    for (int i = 0; i < 17; i++) prog.push_back(enc(procci_pkg::op_add, 0, 0, 0));
    prog.push_back(enc(procci_pkg::op_li, 2, 0, 0));
    prog.push_back(enc(procci_pkg::op_dec, 2, 0, 0));
    prog.push_back(enc(procci_pkg::op_add, 2, 0, 0));
    prog.push_back(enc(procci_pkg::op_li, 3, 0, 3));
    prog.push_back(enc(procci_pkg::op_dec, 3, 0, 0));
    prog.push_back(enc(procci_pkg::op_sw, 0, 0, 8'h40));
    prog.push_back(enc(procci_pkg::op_sw, 2, 0, 8'h41));
    prog.push_back(enc(procci_pkg::op_sw, 3, 0, 8'h42));
    prog.push_back(enc(procci_pkg::op_halt, 0, 0, 0));
    load_program();
    run_program("arithmetic", 1'b0, 8'h00);

    // Countdown loop, the lw at word 3 is rewritten each pass with a lower address
    n = 4 + int'($urandom % 5);
    for (int i = 0; i < n; i++) host_write(procci_pkg::addr_t'(8'h60 + i), $urandom);
    host_write(8'h50, enc(procci_pkg::op_lw, 2, 0, 8'h60 + n - 1));
    prog = {};
    prog.push_back(enc(procci_pkg::op_li, 1, 0, n));
    prog.push_back(enc(procci_pkg::op_lw, 3, 0, 8'h50));
    prog.push_back(enc(procci_pkg::op_sw, 3, 0, 3));
    prog.push_back(32'h0000_0000);
    prog.push_back(enc(procci_pkg::op_add, 0, 2, 0));
    prog.push_back(enc(procci_pkg::op_dec, 3, 0, 0));
    prog.push_back(enc(procci_pkg::op_dec, 1, 0, 0));
    prog.push_back(enc(procci_pkg::op_bnz, 0, 1, 2));
    prog.push_back(enc(procci_pkg::op_sw, 0, 0, 8'h70));
    prog.push_back(enc(procci_pkg::op_halt, 0, 0, 0));
    load_program();
    run_program("load_branch", 1'b0, 8'h00);

    // Random program on a second run
    // r3 is never loaded, so it must start from its reset value
    prog = {};
    for (int r = 0; r < 3; r++) prog.push_back(enc(procci_pkg::op_li, r, 0, $urandom));
    for (int i = 0; i < 6; i++) begin
      prog.push_back(enc(($urandom % 2) ? procci_pkg::op_add : procci_pkg::op_dec,
                         $urandom % 4, $urandom % 4, 0));
    end
    for (int r = 0; r < 4; r++) prog.push_back(enc(procci_pkg::op_sw, r, 0, 8'h40 + r));
    prog.push_back(enc(procci_pkg::op_halt, 0, 0, 0));
    load_program();
    run_program("rerun", 1'b0, 8'h00);

    // Opcode 0xf halts, the later store must not happen
    saved = img[8'h45];
    prog = {};
    prog.push_back(enc(procci_pkg::op_li, 0, 0, $urandom));
    prog.push_back(enc(procci_pkg::op_sw, 0, 0, 8'h44));
    prog.push_back(32'hF000_0000);
    prog.push_back(enc(procci_pkg::op_sw, 0, 0, 8'h45));
    prog.push_back(enc(procci_pkg::op_halt, 0, 0, 0));
    load_program();
    run_program("unknown_opcode", 1'b0, 8'h00);
    err_before = errors;
    host_read(8'h45, saved, "store after unknown opcode");
    finish_test("unknown_opcode_store", err_before);

    $display("tests: %0d, failed tests: %0d, errors: %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
procci_pkg.sv
reset_boot.sv
bus_memory.sv
mini_core.sv
procci_top.sv
tb_clock_gen.sv
procci_chk.sv
procci_tb.sv

//--- run.sh
#!/bin/bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module procci_tb \
  -f sources.f \
  --Mdir obj_dir -o procci_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/procci_sim 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
else
  exit 1
fi
